// File: Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - include

sources:
  - files:
      - verilog/cpuPkg.sv
      - verilog/decodeExBus.sv
      - verilog/instrDecode.sv
      - verilog/regFile.sv
      - verilog/execStage.sv
      - verilog/dataMem.sv
      - verilog/cpuTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/cpuTb.sv

// File: include/cpuCfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// architectural register count, r0 included
`define CPU_REG_COUNT 32

// data memory depth in 32-bit words
`define CPU_DMEM_WORDS 64

// fetch address after reset
`define CPU_PC_RESET 32'h0000_0000

`endif

// File: tb.f
+incdir+include
verilog/cpuPkg.sv
verilog/decodeExBus.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/execStage.sv
verilog/dataMem.sv
verilog/cpuTop.sv
tb/cpuTb.sv

// File: tb/cpuTb.sv
`timescale 1ns/1ps
`include "cpuCfg.svh"

module cpuTb;
    import cpuPkg::*;

    localparam int PROG_LEN     = 23;
    localparam int DRAIN_CYCLES = 8;   // quiet cycles after the last event
    localparam int EV_REG       = 0;
    localparam int EV_STORE     = 1;
    localparam int EV_BRANCH    = 2;

    logic        clk = 1'b0;
    logic        reset;
    logic        stall;
    logic [31:0] instrData;
    logic [31:0] instrAddr;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic        memWrite;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic        branchTaken;

    logic [31:0] rom [PROG_LEN];
    logic [31:0] refRegs [32];
    logic [31:0] refMem [`CPU_DMEM_WORDS];

    // expected events in program order
    int          expKind [$];
    logic [31:0] expA [$];
    logic [31:0] expD [$];

    int          cycles = 0;
    int          cycleLimit = 0;
    int          idleCycles = 0;
    int          kind;
    logic [31:0] evA;
    logic [31:0] evD;
    logic        targetDue = 1'b0;
    logic [31:0] targetPc;

    cpuTop dut_i
    (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .instrData   (instrData),
        .instrAddr   (instrAddr),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .memWdata    (memWdata),
        .branchTaken (branchTaken)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // zero past the end, which is add r0,r0,r0
    function automatic logic [31:0] fetchWord(logic [31:0] addr);
        if (addr[1:0] == 2'b00 && (addr >> 2) < PROG_LEN)
            return rom[addr >> 2];
        return 32'd0;
    endfunction

    assign instrData = fetchWord(instrAddr);

    function void pushEvent(int k, logic [31:0] a, logic [31:0] d);
        expKind.push_back(k);
        expA.push_back(a);
        expD.push_back(d);
    endfunction

    // architectural model of the program, one instruction per step
    function void runReference();
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic        ok;
        int          steps;
        for (int i = 0; i < 32; i++)
            refRegs[i] = 32'd0;
        for (int i = 0; i < `CPU_DMEM_WORDS; i++)
            refMem[i] = 32'd0;
        pc    = `CPU_PC_RESET;
        steps = 0;
        while (pc < PROG_LEN * 4 && steps < 1000)
        begin
            word   = fetchWord(pc);
            a      = refRegs[word[25:21]];
            b      = refRegs[word[20:16]];
            imm    = {{16{word[15]}}, word[15:0]};
            nextPc = pc + 32'd4;
            case (word[31:26])
                RTYPE:
                begin
                    ok = 1'b1;
                    case (word[5:0])
                        FUNCT_ADD: res = a + b;
                        FUNCT_SUB: res = a - b;
                        FUNCT_MUL: res = a * b;
                        default:   ok = 1'b0;
                    endcase
                    if (ok && word[15:11] != 5'd0)
                    begin
                        refRegs[word[15:11]] = res;
                        pushEvent(EV_REG, word[15:11], res);
                    end
                end
                ADDI, LW:
                begin
                    res = a + imm;
                    if (word[31:26] == LW)
                        res = refMem[(res >> 2) % `CPU_DMEM_WORDS]; // memory wraps
                    if (word[20:16] != 5'd0)
                    begin
                        refRegs[word[20:16]] = res;
                        pushEvent(EV_REG, word[20:16], res);
                    end
                end
                SW:
                begin
                    res = a + imm;
                    refMem[(res >> 2) % `CPU_DMEM_WORDS] = b;
                    pushEvent(EV_STORE, res, b);
                end
                BEQ:
                begin
                    if (a == b)
                    begin
                        nextPc = pc + 32'd4 + (imm << 2);
                        pushEvent(EV_BRANCH, pc, nextPc);
                    end
                end
                default: ; // bubble
            endcase
            pc    = nextPc;
            steps = steps + 1;
        end
    endfunction

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected)
            abortRun($sformatf("** Error at %0t: %s = %h, expected %h",
                               $time, name, actual, expected));
    endtask

    initial
    begin
        rom[0]  = iType(ADDI, 5'd0, 5'd1, 16'd5);
        rom[1]  = iType(ADDI, 5'd1, 5'd2, -16'd3);     // forwarded r1
        rom[2]  = rType(5'd1, 5'd2, 5'd3, FUNCT_ADD);
        rom[3]  = rType(5'd3, 5'd1, 5'd4, FUNCT_SUB);
        rom[4]  = rType(5'd4, 5'd3, 5'd5, FUNCT_MUL);
        rom[5]  = iType(SW, 5'd0, 5'd5, 16'd8);
        rom[6]  = iType(LW, 5'd0, 5'd6, 16'd8);
        rom[7]  = rType(5'd6, 5'd6, 5'd7, FUNCT_ADD);  // load result forwarded
        rom[8]  = iType(BEQ, 5'd4, 5'd2, 16'd2);       // taken, to rom[11]
        rom[9]  = iType(ADDI, 5'd0, 5'd8, 16'd99);     // squashed
        rom[10] = iType(ADDI, 5'd0, 5'd8, 16'd77);
        rom[11] = iType(BEQ, 5'd1, 5'd2, 16'd5);       // not taken
        rom[12] = rType(5'd1, 5'd1, 5'd0, FUNCT_ADD);  // r0 target, no event
        rom[13] = rType(5'd0, 5'd1, 5'd9, FUNCT_ADD);
        rom[14] = rType(5'd2, 5'd1, 5'd10, FUNCT_SUB);
        rom[15] = rType(5'd10, 5'd10, 5'd11, FUNCT_MUL);
        rom[16] = iType(SW, 5'd0, 5'd11, 16'd256);     // wraps to word 0
        rom[17] = iType(LW, 5'd0, 5'd12, 16'd0);
        rom[18] = iType(BEQ, 5'd12, 5'd11, 16'd1);     // taken, to rom[20]
        rom[19] = iType(ADDI, 5'd0, 5'd13, 16'd1);
        rom[20] = iType(ADDI, 5'd13, 5'd13, 16'd3);
        rom[21] = iType(ADDI, 5'd0, 5'd14, 16'h7fff);
        rom[22] = rType(5'd14, 5'd14, 5'd15, FUNCT_MUL);

        runReference();
        cycleLimit = 4 * expKind.size() + 100;

        void'($urandom(32'h97bdffac));
        reset = 1'b1;
        stall = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        forever
        begin
            @(posedge clk);
            stall <= ($urandom % 4 == 0); // roughly one cycle in four
        end
    end

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk)
    begin
        cycles = cycles + 1;
        if (reset)
        begin
            if (wbValid || memWrite || branchTaken)
                abortRun("an event appeared while reset was high");
        end
        else
        begin
            if (targetDue)
            begin
                checkValue("instrAddr", instrAddr, targetPc);
                targetDue = 1'b0;
            end
            if (stall && (wbValid || memWrite || branchTaken))
                abortRun("an event appeared while stall was high");
            if (wbValid || memWrite || branchTaken)
            begin
                if (expKind.size() == 0)
                    abortRun("an event appeared after the last expected one");
                kind = expKind.pop_front();
                evA  = expA.pop_front();
                evD  = expD.pop_front();
                checkValue("wbValid", wbValid, kind == EV_REG);
                checkValue("memWrite", memWrite, kind == EV_STORE);
                checkValue("branchTaken", branchTaken, kind == EV_BRANCH);
                if (kind == EV_REG)
                begin
                    checkValue("wbReg", wbReg, evA);
                    checkValue("wbData", wbData, evD);
                end
                else if (kind == EV_STORE)
                begin
                    checkValue("memAddr", memAddr, evA);
                    checkValue("memWdata", memWdata, evD);
                end
                else
                begin
                    targetPc  = evD;  // fetch must sit on the target next cycle
                    targetDue = 1'b1;
                end
            end
            if (expKind.size() == 0)
                idleCycles = idleCycles + 1;
        end
        if (idleCycles == DRAIN_CYCLES)
        begin
            $display("Done: no errors");
            $finish;
        end
        else if (cycles >= cycleLimit)
        begin
            abortRun($sformatf("timeout after %0d cycles with %0d expected events missing",
                               cycles, expKind.size()));
        end
    end

endmodule

// File: verilog/cpuPkg.sv
package cpuPkg;

    // major opcodes, anything else runs as a bubble
    typedef enum logic [5:0]
    {
        RTYPE = 6'h00,
        BEQ   = 6'h04,
        ADDI  = 6'h08,
        LW    = 6'h23,
        SW    = 6'h2B
    } opcode_t;

    // one fetched word, seen as R-type or as I-type
    typedef union packed
    {
        struct packed
        {
            opcode_t    opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed
        {
            opcode_t     opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instrWord_t;

    typedef enum logic [1:0]
    {
        MEMADD = 2'b00, // lw, sw, addi
        BRSUB  = 2'b01, // beq compare
        FUNCT  = 2'b10  // r-type, look at funct
    } aluOp_t;

    typedef enum logic [3:0]
    {
        CTRL_ADD = 4'b0000,
        CTRL_SUB = 4'b0001,
        CTRL_MUL = 4'b0010
    } aluCtrl_t;

    localparam logic [5:0] FUNCT_ADD = 6'd0;
    localparam logic [5:0] FUNCT_SUB = 6'd1;
    localparam logic [5:0] FUNCT_MUL = 6'd2;

endpackage

// File: verilog/cpuTop.sv
`timescale 1ns/1ps

module cpuTop
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic [31:0] instrData,
    output logic [31:0] instrAddr,
    output logic        wbValid,
    output logic [4:0]  wbReg,
    output logic [31:0] wbData,
    output logic        memWrite,
    output logic [31:0] memAddr,
    output logic [31:0] memWdata,
    output logic        branchTaken
);

    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic        redirect;
    logic [31:0] redirectPc;
    logic [31:0] dmemRdata;

    decodeExBus decodeExBus_i ();

    instrDecode instrDecode_i
    (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .instrData  (instrData),
        .rsData     (rsData),
        .rtData     (rtData),
        .wbEn       (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instrAddr  (instrAddr),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .bus        (decodeExBus_i.decode)
    );

    regFile regFile_i
    (
        .clk    (clk),
        .reset  (reset),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .wbEn   (wbValid),
        .wbReg  (wbReg),
        .wbData (wbData),
        .rsData (rsData),
        .rtData (rtData)
    );

    execStage execStage_i
    (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .dmemRdata   (dmemRdata),
        .bus         (decodeExBus_i.execute),
        .wbEn        (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .dmemAddr    (memAddr),
        .dmemWe      (memWrite),
        .dmemWdata   (memWdata),
        .branchTaken (branchTaken)
    );

    dataMem dataMem_i
    (
        .clk   (clk),
        .reset (reset),
        .addr  (memAddr),
        .we    (memWrite),
        .wdata (memWdata),
        .rdata (dmemRdata)
    );

endmodule

// File: verilog/dataMem.sv
`timescale 1ns/1ps
`include "cpuCfg.svh"

module dataMem
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] addr,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int IDX_W = $clog2(`CPU_DMEM_WORDS);

    logic [31:0]      mem [`CPU_DMEM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = addr[IDX_W+1:2]; // upper bits dropped, wraps

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (we)
        begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx]; // combinational, feeds lw writeback directly

    storeAligned: assert property (@(posedge clk) disable iff (reset) we |-> addr[1:0] == 2'b00)
        else $error("unaligned store to %h", addr);

endmodule

// File: verilog/decodeExBus.sv
`timescale 1ns/1ps

// decoded instruction handed from decode to execute, no handshake
interface decodeExBus;
    import cpuPkg::*;

    logic        valid;
    logic [31:0] pc;
    logic [31:0] rsVal;     // already forwarded
    logic [31:0] rtVal;     // already forwarded
    logic [31:0] signExt;
    logic [5:0]  funct;
    logic [4:0]  destReg;
    logic        aluSrc;
    aluOp_t      aluOp;
    logic        isBranch;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;

    modport decode
    (
        output valid, pc, rsVal, rtVal, signExt, funct, destReg,
        output aluSrc, aluOp, isBranch, memRead, memWrite, regWrite
    );

    modport execute
    (
        input valid, pc, rsVal, rtVal, signExt, funct, destReg,
        input aluSrc, aluOp, isBranch, memRead, memWrite, regWrite
    );

endinterface

// File: verilog/execStage.sv
`timescale 1ns/1ps

module execStage
(
    input  logic         clk,
    input  logic         reset,
    input  logic         stall,
    input  logic [31:0]  dmemRdata,
    decodeExBus.execute  bus,
    output logic         wbEn,
    output logic [4:0]   wbReg,
    output logic [31:0]  wbData,
    output logic         redirect,
    output logic [31:0]  redirectPc,
    output logic [31:0]  dmemAddr,
    output logic         dmemWe,
    output logic [31:0]  dmemWdata,
    output logic         branchTaken
);
    import cpuPkg::*;

    logic [31:0] opA;
    logic [31:0] opB;
    aluCtrl_t    aluCtrl;
    logic        ctrlOk;
    logic [31:0] aluResult;
    logic        zero;
    logic        fire;

    assign opA = bus.rsVal;
    assign opB = bus.aluSrc ? bus.signExt : bus.rtVal; // immediate or rt

    // alu control from aluOp and funct
    always_comb
    begin
        aluCtrl = CTRL_ADD;
        ctrlOk  = 1'b1;
        case (bus.aluOp)
            MEMADD: aluCtrl = CTRL_ADD;
            BRSUB:  aluCtrl = CTRL_SUB;
            FUNCT:
            begin
                case (bus.funct)
                    FUNCT_ADD: aluCtrl = CTRL_ADD;
                    FUNCT_SUB: aluCtrl = CTRL_SUB;
                    FUNCT_MUL: aluCtrl = CTRL_MUL;
                    default:   ctrlOk  = 1'b0; // unknown funct, no effect
                endcase
            end
            default: ctrlOk = 1'b0;
        endcase
    end

    always_comb
    begin
        case (aluCtrl)
            CTRL_SUB: aluResult = opA - opB;
            CTRL_MUL: aluResult = opA * opB; // low 32 bits only
            default:  aluResult = opA + opB;
        endcase
    end

    assign zero = (opA == opB);

    // nothing leaves this stage while stalled or empty
    assign fire = bus.valid && !stall && ctrlOk;

    assign wbEn   = fire && bus.regWrite && bus.destReg != 5'd0;
    assign wbReg  = bus.destReg;
    assign wbData = bus.memRead ? dmemRdata : aluResult;

    assign dmemAddr  = aluResult;
    assign dmemWe    = fire && bus.memWrite;
    assign dmemWdata = bus.rtVal;

    // beq target relative to the following instruction
    assign branchTaken = fire && bus.isBranch && zero;
    assign redirect    = branchTaken;
    assign redirectPc  = bus.pc + 32'd4 + {bus.signExt[29:0], 2'b00};

    // decode never marks one instruction as both store and register write
    noWbOnStore: assert property (@(posedge clk) disable iff (reset) !(dmemWe && wbEn))
        else $error("store and writeback in the same cycle");

endmodule

// File: verilog/instrDecode.sv
`timescale 1ns/1ps
`include "cpuCfg.svh"

module instrDecode
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic [31:0] instrData,
    input  logic [31:0] rsData,
    input  logic [31:0] rtData,
    input  logic        wbEn,
    input  logic [4:0]  wbReg,
    input  logic [31:0] wbData,
    input  logic        redirect,
    input  logic [31:0] redirectPc,
    output logic [31:0] instrAddr,
    output logic [4:0]  rsAddr,
    output logic [4:0]  rtAddr,
    decodeExBus.decode  bus
);
    import cpuPkg::*;

    logic [31:0] pc;
    instrWord_t  instr;
    logic [31:0] signExt;
    logic        known;
    logic        aluSrc;
    aluOp_t      aluOp;
    logic        isBranch;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;
    logic        useRd;
    logic [31:0] rsFwd;
    logic [31:0] rtFwd;

    assign instrAddr = pc;
    assign instr     = instrData;
    assign rsAddr    = instr.r.rs;
    assign rtAddr    = instr.r.rt;
    assign signExt   = {{16{instr.i.imm[15]}}, instr.i.imm};

    // control decode from the opcode
    always_comb
    begin
        known    = 1'b1;
        aluSrc   = 1'b0;
        aluOp    = MEMADD;
        isBranch = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        useRd    = 1'b0;
        case (instr.r.opcode)
            RTYPE:
            begin
                aluOp    = FUNCT;
                regWrite = 1'b1;
                useRd    = 1'b1;
            end
            ADDI:
            begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            LW:
            begin
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                regWrite = 1'b1;
            end
            SW:
            begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            BEQ:
            begin
                aluOp    = BRSUB;
                isBranch = 1'b1;
            end
            default: known = 1'b0; // bubble
        endcase
    end

    // writeback in flight wins over the register file read
    assign rsFwd = (wbEn && wbReg == rsAddr) ? wbData : rsData;
    assign rtFwd = (wbEn && wbReg == rtAddr) ? wbData : rtData;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc        <= `CPU_PC_RESET;
            bus.valid <= 1'b0;
        end
        else if (redirect)
        begin
            pc        <= redirectPc;
            bus.valid <= 1'b0; // squash the wrong-path fetch
        end
        else if (!stall)
        begin
            pc        <= pc + 32'd4;
            bus.valid <= known;
        end
    end

    // payload, only meaningful while valid
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            bus.pc       <= pc;
            bus.rsVal    <= rsFwd;
            bus.rtVal    <= rtFwd;
            bus.signExt  <= signExt;
            bus.funct    <= instr.r.funct;
            bus.destReg  <= useRd ? instr.r.rd : instr.i.rt;
            bus.aluSrc   <= aluSrc;
            bus.aluOp    <= aluOp;
            bus.isBranch <= isBranch;
            bus.memRead  <= memRead;
            bus.memWrite <= memWrite;
            bus.regWrite <= regWrite;
        end
    end

    // branch targets must keep fetch on word boundaries
    pcAligned: assert property (@(posedge clk) disable iff (reset) instrAddr[1:0] == 2'b00)
        else $error("fetch address %h not word aligned", instrAddr);

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps
`include "cpuCfg.svh"

module regFile
(
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic        wbEn,
    input  logic [4:0]  wbReg,
    input  logic [31:0] wbData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wbEn && wbReg != 5'd0) // r0 stays zero
        begin
            regs[wbReg] <= wbData;
        end
    end

    // old value during a write, decode forwards the new one
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

    // execute drops r0 writes before they get here
    r0NoWrite: assert property (@(posedge clk) disable iff (reset) wbEn |-> wbReg != 5'd0)
        else $error("writeback addressed to r0 with data %h", wbData);

endmodule
